//--- build.f
verilog/ltssmPkg.sv
verilog/laneOsDetect.sv
verilog/loopbackSm.sv
verilog/txOsGen.sv
verilog/loopbackTop.sv
test/loopbackTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the loopback testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module loopbackTb -f build.f -o simLoopback

output=$(./obj_dir/simLoopback)
echo "$output"
echo "$output" | grep -q "^Simulation PASSED$"

//--- test/loopbackTb.sv
`timescale 1ns/10ps

module loopbackTb;

    import ltssmPkg::*;

    localparam int TEST_COUNT  = 6;
    localparam int WATCHDOG_NS = 40 * OS_LEN * TEST_COUNT * 20;

    logic                    sys_clk;
    logic                    rst_n;
    logic [3:0]              ltssmState;
    logic                    lbRequest;
    logic [LANE_COUNT-1:0]   lbLaneReq;
    logic [LANE_COUNT*8-1:0] rxSym;
    logic [LANE_COUNT-1:0]   rxIsK;
    logic [LANE_COUNT-1:0]   rxValid;
    logic [LANE_COUNT*8-1:0] txSym;
    logic [LANE_COUNT-1:0]   txIsK;
    logic                    lbMaster;
    logic                    lbSlave;
    logic                    exitDone;
    logic [2:0]              lbSubstate;

    logic                  watchArmed;
    logic [1:0]            watchType;
    logic [LANE_COUNT-1:0] watchMask;
    int                    watchIdx = 0;
    int                    setsChecked = 0;
    int                    compareErrors = 0;
    int                    checkErrors;
    int                    errMark;
    int                    passCount;
    int                    failCount;
    string                 curTest;

    loopbackTop dut0 (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .ltssmState (ltssmState),
        .lbRequest  (lbRequest),
        .lbLaneReq  (lbLaneReq),
        .rxSym      (rxSym),
        .rxIsK      (rxIsK),
        .rxValid    (rxValid),
        .txSym      (txSym),
        .txIsK      (txIsK),
        .lbMaster   (lbMaster),
        .lbSlave    (lbSlave),
        .exitDone   (exitDone),
        .lbSubstate (lbSubstate)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // {isK, data} of every ordered-set position.
    function automatic logic [8:0] expectedOsSym(input logic [1:0] setType, input int index);
        if (index == 0) return {1'b1, 8'hBC};
        if (setType == OS_EIDLE) return {1'b1, 8'h7C};
        case (index)
            1, 2: return {1'b1, 8'hF7};
            3: return {1'b0, 8'h20};
            4: return {1'b0, 8'h02};
            5: return {1'b0, (setType == OS_T1_LB) ? 8'h04 : 8'h00};  // loopback is bit 2.
            default: return {1'b0, 8'h4A};
        endcase
    endfunction

    always @(negedge sys_clk) begin
        logic       started;
        logic [8:0] expSym;
        logic [8:0] gotSym;
        started = (watchIdx != 0);
        for (int lane = 0; lane < LANE_COUNT; lane++) begin
            if (watchMask[lane] && txIsK[lane] && (txSym[lane*8 +: 8] == 8'hBC)) begin
                started = 1'b1;  // a set begins with COM.
            end
        end
        if (!watchArmed) begin
            watchIdx = 0;
        end else begin
            for (int lane = 0; lane < LANE_COUNT; lane++) begin
                gotSym = {txIsK[lane], txSym[lane*8 +: 8]};
                expSym = (started && watchMask[lane]) ? expectedOsSym(watchType, watchIdx) : 9'h000;
                if ((started || !watchMask[lane]) && (gotSym !== expSym)) begin
                    $display("ERROR %s lane %0d symbol %0d: expected %h, actual %h",
                             curTest, lane, watchIdx, expSym, gotSym);
                    compareErrors++;
                end
            end
            if (started) begin
                watchIdx = watchIdx + 1;
                if (watchIdx == ((watchType == OS_EIDLE) ? EIOS_LEN : OS_LEN)) begin
                    watchIdx = 0;
                    setsChecked++;
                end
            end
        end
    end

    task automatic reportError(input string what, input int expected, input int actual);
        $display("ERROR %s %s: expected %0h, actual %0h", curTest, what, expected, actual);
        checkErrors++;
    endtask

    task automatic startTest(input string name);
        curTest = name;
        errMark = checkErrors + compareErrors;
    endtask

    task automatic finishTest();
        int errs;
        errs = checkErrors + compareErrors - errMark;
        if (errs == 0) begin
            passCount++;
            $display("test %s: ok", curTest);
        end else begin
            failCount++;
            $display("test %s: %0d errors", curTest, errs);
        end
    endtask

    // one ordered set into the masked lanes with random gaps between strobes.
    task automatic sendRxSet(input logic [LANE_COUNT-1:0] mask, input logic [1:0] setType,
                             input int badIdx);
        logic [8:0] sym;
        int         setLen;
        int         gap;
        setLen = (setType == OS_EIDLE) ? EIOS_LEN : OS_LEN;
        for (int idx = 0; idx < setLen; idx++) begin
            gap = int'($urandom_range(0, 2));
            repeat (gap) begin
                @(posedge sys_clk);
                rxValid <= '0;
            end
            sym = expectedOsSym(setType, idx);
            if (idx == badIdx) begin
                sym[7:0] = sym[7:0] ^ 8'h01;
            end
            @(posedge sys_clk);
            rxSym   <= {LANE_COUNT{sym[7:0]}};
            rxIsK   <= {LANE_COUNT{sym[8]}};
            rxValid <= mask;
        end
        @(posedge sys_clk);
        rxValid <= '0;
    endtask

    task automatic waitSets(input int count);
        int target;
        target = setsChecked + count;
        while (setsChecked < target) begin
            @(posedge sys_clk);
        end
    endtask

    task automatic waitTxIdle();
        int quiet;
        quiet = 0;
        while (quiet < 2) begin  // sets back to back leave a one-cycle gap.
            @(negedge sys_clk);
            quiet = ((txSym == '0) && (txIsK == '0)) ? quiet + 1 : 0;
        end
        @(posedge sys_clk);
    endtask

    task automatic countExitPulses(output int pulses);
        pulses = 0;
        do begin
            @(negedge sys_clk);
            pulses = pulses + int'(exitDone);
        end while (lbSubstate != LB_DONE);
        repeat (4) begin
            @(negedge sys_clk);
            pulses = pulses + int'(exitDone);
        end
        @(posedge sys_clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired during test %s, the DUT stopped responding", curTest);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [LANE_COUNT-1:0] reqMask;
        logic                  lastLane;
        int                    pulses;
        rst_n       = 1'b0;
        ltssmState  = DETECT;
        lbRequest   = 1'b0;
        lbLaneReq   = '0;
        rxSym       = '0;
        rxIsK       = '0;
        rxValid     = '0;
        watchArmed  = 1'b0;
        watchType   = OS_NONE;
        watchMask   = '0;
        checkErrors = 0;
        passCount   = 0;
        failCount   = 0;
        curTest     = "reset";
        void'($urandom(91));
        repeat (4) @(posedge sys_clk);
        rst_n <= 1'b1;

        startTest("reset state");
        @(negedge sys_clk);
        if (lbSubstate !== LB_IDLE) reportError("lbSubstate", int'(LB_IDLE), int'(lbSubstate));
        if (lbMaster !== 1'b0) reportError("lbMaster", 0, int'(lbMaster));
        if (lbSlave !== 1'b0) reportError("lbSlave", 0, int'(lbSlave));
        if (exitDone !== 1'b0) reportError("exitDone", 0, int'(exitDone));
        if (txSym !== '0) reportError("txSym", 0, int'(txSym));
        if (txIsK !== '0) reportError("txIsK", 0, int'(txIsK));
        @(posedge sys_clk);
        finishTest();

        startTest("master entry transmit");
        reqMask    = LANE_COUNT'($urandom_range(1, (1 << LANE_COUNT) - 1));
        watchType  <= OS_T1_LB;
        watchMask  <= reqMask;
        watchArmed <= 1'b1;
        ltssmState <= LOOPBACK;
        lbRequest  <= 1'b1;
        lbLaneReq  <= reqMask;
        waitSets(2);  // the second set is the re-send on osDone.
        if (lbSubstate !== LB_ENTRY_MASTER) reportError("lbSubstate", 1, int'(lbSubstate));
        finishTest();

        startTest("corrupt sets ignored");
        sendRxSet(reqMask, OS_T1_LB, 9);
        sendRxSet(reqMask, OS_T1, -1);
        repeat (3) @(negedge sys_clk);
        if (lbSubstate !== LB_ENTRY_MASTER) reportError("lbSubstate", 1, int'(lbSubstate));
        if (lbMaster !== 1'b0) reportError("lbMaster", 0, int'(lbMaster));
        @(posedge sys_clk);
        finishTest();

        startTest("master reaches active");
        for (int lane = 0; lane < LANE_COUNT; lane++) begin
            if (reqMask[lane]) begin
                lastLane = ((reqMask >> (lane + 1)) == '0);
                sendRxSet(LANE_COUNT'(1) << lane, OS_T1_LB, -1);
                @(negedge sys_clk);
                if (lbMaster !== 1'b0) reportError("lbMaster 1 clock on", 0, int'(lbMaster));
                @(negedge sys_clk);
                if (lbMaster !== lastLane) begin
                    reportError("lbMaster 2 clocks on", int'(lastLane), int'(lbMaster));
                end
                @(posedge sys_clk);
            end
        end
        if (lbSubstate !== LB_ACTIVE) reportError("lbSubstate", int'(LB_ACTIVE), int'(lbSubstate));
        waitTxIdle();
        watchArmed <= 1'b0;
        finishTest();

        startTest("master exit");
        @(posedge sys_clk);
        watchType  <= OS_EIDLE;
        watchMask  <= '1;
        watchArmed <= 1'b1;
        lbRequest  <= 1'b0;
        waitSets(1);
        watchArmed <= 1'b0;
        countExitPulses(pulses);
        if (pulses != 1) reportError("exitDone pulses", 1, pulses);
        if (lbMaster !== 1'b0) reportError("lbMaster", 0, int'(lbMaster));
        if (lbSubstate !== LB_DONE) reportError("lbSubstate", int'(LB_DONE), int'(lbSubstate));
        ltssmState <= L0;
        @(posedge sys_clk);
        @(negedge sys_clk);
        if (lbSubstate !== LB_IDLE) reportError("lbSubstate", int'(LB_IDLE), int'(lbSubstate));
        @(posedge sys_clk);
        finishTest();

        startTest("slave path");
        ltssmState <= LOOPBACK;
        @(posedge sys_clk);
        @(negedge sys_clk);
        if (lbSlave !== 1'b1) reportError("lbSlave", 1, int'(lbSlave));
        if (lbSubstate !== LB_ACTIVE) reportError("lbSubstate", int'(LB_ACTIVE), int'(lbSubstate));
        if (txIsK !== '0) reportError("txIsK", 0, int'(txIsK));
        @(posedge sys_clk);
        sendRxSet(LANE_COUNT'(1) << $urandom_range(0, LANE_COUNT - 1), OS_EIDLE, -1);
        countExitPulses(pulses);
        if (pulses != 1) reportError("exitDone pulses", 1, pulses);
        if (lbSlave !== 1'b0) reportError("lbSlave", 0, int'(lbSlave));
        ltssmState <= L0;
        @(posedge sys_clk);
        finishTest();

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/laneOsDetect.sv
`timescale 1ns/10ps

module laneOsDetect (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic [7:0] rxSym,
    input  logic       rxIsK,
    input  logic       rxValid,
    input  logic       clrSeen,
    output logic       ts1Seen,
    output logic       ts1LbSeen,
    output logic       eiosSeen
);

    import ltssmPkg::*;

    trainCtrl_u rxWord;
    logic       inSet;
    logic       isEios;
    logic [3:0] symIdx;
    logic       lbBit;
    logic       comSeen;
    logic       eiosTrack;
    logic       symOk;
    logic       symStep;
    logic       ts1Done;
    logic       eiosDone;

    assign rxWord.raw = rxSym;
    assign comSeen    = rxIsK && (rxWord.raw == COM);
    assign symStep    = rxValid && inSet && !comSeen;

    // The symbol right after COM tells an EIOS from a TS1.
    assign eiosTrack = (symIdx == 4'd1) ? (rxIsK && (rxWord.raw == IDL)) : isEios;

    always_comb begin
        if (eiosTrack) begin
            symOk = rxIsK && (rxWord.raw == IDL);
        end else if (symIdx < 4'(TRAIN_CTRL_IDX)) begin
            symOk = 1'b1;  // link, lane, N_FTS and rate fields are not checked.
        end else if (symIdx == 4'(TRAIN_CTRL_IDX)) begin
            symOk = !rxIsK;
        end else begin
            symOk = !rxIsK && (rxWord.raw == D10_2);
        end
    end

    assign eiosDone = symStep && symOk && eiosTrack && (symIdx == 4'(EIOS_LEN - 1));
    assign ts1Done  = symStep && symOk && !eiosTrack && (symIdx == 4'(OS_LEN - 1));

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            inSet  <= 1'b0;
            isEios <= 1'b0;
            symIdx <= 4'd0;
        end else if (rxValid) begin
            if (comSeen) begin
                inSet  <= 1'b1;  // any COM restarts the match.
                symIdx <= 4'd1;
            end else if (inSet) begin
                isEios <= eiosTrack;
                symIdx <= symIdx + 4'd1;
                if (!symOk || eiosDone || ts1Done) begin
                    inSet <= 1'b0;  // wait for the next COM.
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (symStep && (symIdx == 4'(TRAIN_CTRL_IDX))) begin
            lbBit <= rxWord.fields.loopback;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ts1Seen   <= 1'b0;
            ts1LbSeen <= 1'b0;
            eiosSeen  <= 1'b0;
        end else begin
            if (clrSeen) begin
                ts1Seen   <= 1'b0;
                ts1LbSeen <= 1'b0;
                eiosSeen  <= 1'b0;
            end
            // a set completing in the clear cycle is kept.
            if (ts1Done && lbBit) begin
                ts1LbSeen <= 1'b1;
            end
            if (ts1Done && !lbBit) begin
                ts1Seen <= 1'b1;
            end
            if (eiosDone) begin
                eiosSeen <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/loopbackSm.sv
`timescale 1ns/10ps

module loopbackSm (
    input  logic                            sys_clk,
    input  logic                            rst_n,
    input  logic [3:0]                      ltssmState,
    input  logic                            lbRequest,
    input  logic [ltssmPkg::LANE_COUNT-1:0] lbLaneReq,
    input  logic [ltssmPkg::LANE_COUNT-1:0] laneTs1,
    input  logic [ltssmPkg::LANE_COUNT-1:0] laneTs1Lb,
    input  logic [ltssmPkg::LANE_COUNT-1:0] laneEios,
    input  logic                            osDone,
    output logic                            osSend,
    output logic [1:0]                      osType,
    output logic [ltssmPkg::LANE_COUNT-1:0] txLaneMask,
    output logic                            clrSeen,
    output logic                            lbMaster,
    output logic                            lbSlave,
    output logic                            exitDone,
    output logic [2:0]                      lbSubstate
);

    import ltssmPkg::*;

    logic [2:0]            nextSub;
    logic                  sendNow;
    logic [1:0]            sendType;
    logic [LANE_COUNT-1:0] sendMask;
    logic [LANE_COUNT-1:0] masterLanes;
    logic                  busy;
    logic                  flagsValid;
    logic                  allEchoed;

    // Detector flags are stale in the cycle their clear is still pending.
    assign flagsValid = !clrSeen;
    assign allEchoed  = ((laneTs1Lb & masterLanes) == masterLanes);

    always_comb begin
        nextSub  = lbSubstate;
        sendNow  = 1'b0;
        sendType = OS_T1_LB;
        sendMask = masterLanes;
        case (lbSubstate)
            LB_IDLE: begin
                if (ltssmState == LOOPBACK) begin
                    if (lbRequest && (|lbLaneReq)) begin
                        nextSub  = LB_ENTRY_MASTER;
                        sendNow  = 1'b1;
                        sendMask = lbLaneReq;
                    end else begin
                        nextSub = LB_ACTIVE;  // no request, so this side is the slave.
                    end
                end
            end
            LB_ENTRY_MASTER: begin
                if (flagsValid && allEchoed) begin
                    nextSub = LB_ACTIVE;
                end else if (osDone) begin
                    sendNow = 1'b1;  // keep the TS1 stream going until echoed.
                end
            end
            LB_ACTIVE: begin
                if (lbMaster) begin
                    if (!lbRequest && !busy) begin
                        nextSub  = LB_EXIT_SEND;
                        sendNow  = 1'b1;
                        sendType = OS_EIDLE;
                        sendMask = '1;
                    end
                end else if (flagsValid && ((|laneEios) || (|laneTs1))) begin
                    nextSub = LB_EXIT_IDLE;
                end
            end
            LB_EXIT_SEND: begin
                if (osDone) begin
                    nextSub = LB_EXIT_IDLE;
                end
            end
            LB_EXIT_IDLE: begin
                nextSub = LB_DONE;
            end
            LB_DONE: begin
                if (ltssmState != LOOPBACK) begin
                    nextSub = LB_IDLE;
                end
            end
            default: begin
                nextSub = LB_IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            lbSubstate  <= LB_IDLE;
            clrSeen     <= 1'b0;
            osSend      <= 1'b0;
            osType      <= OS_NONE;
            txLaneMask  <= '0;
            masterLanes <= '0;
            busy        <= 1'b0;
            lbMaster    <= 1'b0;
            lbSlave     <= 1'b0;
            exitDone    <= 1'b0;
        end else begin
            lbSubstate <= nextSub;
            clrSeen    <= (nextSub != lbSubstate);
            osSend     <= sendNow;
            busy       <= sendNow || (busy && !osDone);
            exitDone   <= (lbSubstate == LB_EXIT_IDLE);
            if (sendNow) begin
                osType     <= sendType;
                txLaneMask <= sendMask;
            end
            if ((lbSubstate == LB_IDLE) && (nextSub == LB_ENTRY_MASTER)) begin
                masterLanes <= lbLaneReq;
            end
            if ((lbSubstate == LB_ENTRY_MASTER) && (nextSub == LB_ACTIVE)) begin
                lbMaster <= 1'b1;
            end
            if ((lbSubstate == LB_IDLE) && (nextSub == LB_ACTIVE)) begin
                lbSlave <= 1'b1;
            end
            if (lbSubstate == LB_EXIT_IDLE) begin
                lbMaster <= 1'b0;
                lbSlave  <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/loopbackTop.sv
`timescale 1ns/10ps

module loopbackTop (
    input  logic                              sys_clk,
    input  logic                              rst_n,
    input  logic [3:0]                        ltssmState,
    input  logic                              lbRequest,
    input  logic [ltssmPkg::LANE_COUNT-1:0]   lbLaneReq,
    input  logic [ltssmPkg::LANE_COUNT*8-1:0] rxSym,
    input  logic [ltssmPkg::LANE_COUNT-1:0]   rxIsK,
    input  logic [ltssmPkg::LANE_COUNT-1:0]   rxValid,
    output logic [ltssmPkg::LANE_COUNT*8-1:0] txSym,
    output logic [ltssmPkg::LANE_COUNT-1:0]   txIsK,
    output logic                              lbMaster,
    output logic                              lbSlave,
    output logic                              exitDone,
    output logic [2:0]                        lbSubstate
);

    import ltssmPkg::*;

    logic [LANE_COUNT-1:0] laneTs1;
    logic [LANE_COUNT-1:0] laneTs1Lb;
    logic [LANE_COUNT-1:0] laneEios;
    logic                  clrSeen;
    logic                  osSend;
    logic [1:0]            osType;
    logic [LANE_COUNT-1:0] txLaneMask;
    logic                  osDone;

    for (genvar lane = 0; lane < LANE_COUNT; lane++) begin : gLane
        laneOsDetect laneDetect (
            .sys_clk   (sys_clk),
            .rst_n     (rst_n),
            .rxSym     (rxSym[lane*8 +: 8]),
            .rxIsK     (rxIsK[lane]),
            .rxValid   (rxValid[lane]),
            .clrSeen   (clrSeen),
            .ts1Seen   (laneTs1[lane]),
            .ts1LbSeen (laneTs1Lb[lane]),
            .eiosSeen  (laneEios[lane])
        );
    end

    loopbackSm lbSm (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .ltssmState (ltssmState),
        .lbRequest  (lbRequest),
        .lbLaneReq  (lbLaneReq),
        .laneTs1    (laneTs1),
        .laneTs1Lb  (laneTs1Lb),
        .laneEios   (laneEios),
        .osDone     (osDone),
        .osSend     (osSend),
        .osType     (osType),
        .txLaneMask (txLaneMask),
        .clrSeen    (clrSeen),
        .lbMaster   (lbMaster),
        .lbSlave    (lbSlave),
        .exitDone   (exitDone),
        .lbSubstate (lbSubstate)
    );

    txOsGen txGen (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .osSend     (osSend),
        .osType     (osType),
        .txLaneMask (txLaneMask),
        .txSym      (txSym),
        .txIsK      (txIsK),
        .osDone     (osDone)
    );

endmodule

//--- verilog/ltssmPkg.sv
package ltssmPkg;

    // number of lanes in the link. The design also builds for 1 or 2.
    localparam int LANE_COUNT = 4;

    // symbol codes of the unscrambled 8b domain.
    localparam logic [7:0] COM   = 8'hBC;  // K28.5.
    localparam logic [7:0] IDL   = 8'h7C;  // K28.3.
    localparam logic [7:0] SKP   = 8'h1C;  // K28.0.
    localparam logic [7:0] D10_2 = 8'h4A;  // filler symbol of TS1.
    localparam logic [7:0] PAD   = 8'hF7;  // K23.7.

    // ordered-set lengths in symbols, COM included.
    localparam int OS_LEN   = 16;
    localparam int EIOS_LEN = 4;

    // the training-control symbol sits here within a TS1.
    localparam int TRAIN_CTRL_IDX = 5;

    localparam logic [1:0] OS_NONE  = 2'd0;
    localparam logic [1:0] OS_T1    = 2'd1;
    localparam logic [1:0] OS_T1_LB = 2'd2;  // TS1 with the loopback bit set.
    localparam logic [1:0] OS_EIDLE = 2'd3;

    // main link state codes.
    localparam logic [3:0] DETECT   = 4'd0;
    localparam logic [3:0] POLLING  = 4'd1;
    localparam logic [3:0] CONFIG   = 4'd2;
    localparam logic [3:0] L0       = 4'd3;
    localparam logic [3:0] RECOVERY = 4'd7;
    localparam logic [3:0] LOOPBACK = 4'd8;
    localparam logic [3:0] HOTRST   = 4'd9;
    localparam logic [3:0] DISABLED = 4'd10;

    // loopback substates. Codes 3 and 7 are unused.
    localparam logic [2:0] LB_IDLE         = 3'd0;
    localparam logic [2:0] LB_ENTRY_MASTER = 3'd1;
    localparam logic [2:0] LB_ACTIVE       = 3'd2;
    localparam logic [2:0] LB_EXIT_SEND    = 3'd4;
    localparam logic [2:0] LB_EXIT_IDLE    = 3'd5;
    localparam logic [2:0] LB_DONE         = 3'd6;

    // One symbol seen either as a plain byte or as the TS1 training-control field.
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] reserved;
            logic       scrambleOff;
            logic       loopback;
            logic       disableLink;
            logic       hotReset;
        } fields;
    } trainCtrl_u;

endpackage

//--- verilog/txOsGen.sv
`timescale 1ns/10ps

module txOsGen (
    input  logic                              sys_clk,
    input  logic                              rst_n,
    input  logic                              osSend,
    input  logic [1:0]                        osType,
    input  logic [ltssmPkg::LANE_COUNT-1:0]   txLaneMask,
    output logic [ltssmPkg::LANE_COUNT*8-1:0] txSym,
    output logic [ltssmPkg::LANE_COUNT-1:0]   txIsK,
    output logic                              osDone
);

    import ltssmPkg::*;

    logic                  active;
    logic [1:0]            curType;
    logic [LANE_COUNT-1:0] curMask;
    logic [3:0]            symIdx;
    logic [3:0]            lastIdx;
    trainCtrl_u            txCtrl;
    logic [7:0]            osByte;
    logic                  osIsK;

    assign lastIdx = (curType == OS_EIDLE) ? 4'(EIOS_LEN - 1) : 4'(OS_LEN - 1);
    assign osDone  = active && (symIdx == lastIdx);

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            symIdx <= 4'd0;
        end else if (osSend) begin
            active <= 1'b1;
            symIdx <= 4'd0;
        end else if (active) begin
            symIdx <= symIdx + 4'd1;
            if (osDone) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (osSend) begin
            curType <= osType;
            curMask <= txLaneMask;
        end
    end

    always_comb begin
        txCtrl.raw             = 8'h00;
        txCtrl.fields.loopback = (curType == OS_T1_LB);
        osByte                 = D10_2;
        osIsK                  = 1'b0;
        if (symIdx == 4'd0) begin
            osByte = COM;
            osIsK  = 1'b1;
        end else if (curType == OS_EIDLE) begin
            osByte = IDL;
            osIsK  = 1'b1;
        end else begin
            case (symIdx)
                4'd1, 4'd2: begin
                    osByte = PAD;  // link and lane numbers are not assigned yet.
                    osIsK  = 1'b1;
                end
                4'd3: osByte = 8'h20;  // N_FTS.
                4'd4: osByte = 8'h02;  // 2.5 GT/s only.
                4'(TRAIN_CTRL_IDX): osByte = txCtrl.raw;
                default: osByte = D10_2;
            endcase
        end
    end

    always_comb begin
        for (int lane = 0; lane < LANE_COUNT; lane++) begin
            txSym[lane*8 +: 8] = (active && curMask[lane]) ? osByte : 8'h00;
            txIsK[lane]        = active && curMask[lane] && osIsK;
        end
    end

endmodule
